// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mmio_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/100ps

SOURCES := $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: list.f
+incdir+rtl
rtl/mmio_pkg.sv
rtl/mmio_controller.sv
rtl/mmio_gpo.sv
rtl/mmio_ddfs.sv
rtl/mmio_adsr.sv
rtl/i2s_tx.sv
rtl/mmio_top.sv
tests/tb_mmio_top.sv

// File: rtl/i2s_tx.sv
`timescale 1ns/100ps
`default_nettype none

`include "mmio_defs.svh"

module i2s_tx #(
    parameter int SCLK_DIV = `I2S_SCLK_DIV
) (
    input  logic           clk,
    input  logic           arst_n,
    input  mmio_pkg::pcm_t audio_l,
    input  mmio_pkg::pcm_t audio_r,
    output logic           tx_mclk,
    output logic           tx_sclk,
    output logic           tx_lrclk,
    output logic           tx_sd
);

    import mmio_pkg::*;

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             div_tick;
    logic             sclk_fall;
    logic [4:0]       bit_cnt;
    logic [4:0]       bit_cnt_next;
    logic [31:0]      shift_reg;

    assign div_tick     = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign sclk_fall    = div_tick && tx_sclk;
    assign bit_cnt_next = bit_cnt + 5'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            tx_mclk <= 1'b0;
            tx_sclk <= 1'b0;
        end else begin
            tx_mclk <= ~tx_mclk;
            div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
            if (div_tick) begin
                tx_sclk <= ~tx_sclk;
            end
        end
    end

    // Everything below moves on the falling edge of sclk
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt   <= '0;
            tx_lrclk  <= 1'b0;
            tx_sd     <= 1'b0;
            shift_reg <= '0;
        end else if (sclk_fall) begin
            bit_cnt  <= bit_cnt_next;
            tx_lrclk <= bit_cnt_next[4];
            // Last right bit goes out as the new frame is latched
            tx_sd    <= shift_reg[31];
            if (bit_cnt == 5'd31) begin
                shift_reg <= {audio_l, audio_r};
            end else begin
                shift_reg <= {shift_reg[30:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/mmio_adsr.sv
`timescale 1ns/100ps
`default_nettype none

`include "mmio_defs.svh"

module mmio_adsr (
    input  logic                clk,
    input  logic                arst_n,
    input  mmio_pkg::slot_req_t req,
    output mmio_pkg::word_t     read_data,
    output mmio_pkg::env_t      env
);

    import mmio_pkg::*;

    env_t  attack_step;
    env_t  decay_step;
    env_t  release_step;
    env_t  sustain_level;
    word_t sus_time;
    word_t sus_cnt;
    logic  start;

    logic [16:0] attack_sum;
    logic [16:0] decay_floor;
    logic [32:0] sus_next;

    adsr_state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            attack_step   <= '0;
            decay_step    <= '0;
            sustain_level <= '0;
            sus_time      <= '0;
            release_step  <= '0;
        end else if (req.write) begin
            case (req.reg_addr)
                `ADSR_REG_ATTACK:   attack_step   <= req.write_data[15:0];
                `ADSR_REG_DECAY:    decay_step    <= req.write_data[15:0];
                `ADSR_REG_SUSTAIN:  sustain_level <= req.write_data[15:0];
                `ADSR_REG_SUS_TIME: sus_time      <= req.write_data;
                `ADSR_REG_RELEASE:  release_step  <= req.write_data[15:0];
                default: ;
            endcase
        end
    end

    assign start       = req.write && (req.reg_addr == `ADSR_REG_START);
    assign attack_sum  = {1'b0, env} + {1'b0, attack_step};
    assign decay_floor = {1'b0, sustain_level} + {1'b0, decay_step};
    assign sus_next    = {1'b0, sus_cnt} + 33'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ADSR_IDLE;
            env     <= '0;
            sus_cnt <= '0;
        end else if (start) begin
            // Retrigger from the current level
            state   <= ADSR_ATTACK;
            sus_cnt <= '0;
        end else begin
            case (state)
                ADSR_ATTACK: begin
                    if (attack_sum >= {1'b0, `ENV_MAX}) begin
                        env   <= `ENV_MAX;
                        state <= ADSR_DECAY;
                    end else begin
                        env <= attack_sum[15:0];
                    end
                end
                ADSR_DECAY: begin
                    if ({1'b0, env} <= decay_floor) begin
                        env     <= sustain_level;
                        sus_cnt <= '0;
                        state   <= ADSR_SUSTAIN;
                    end else begin
                        env <= env - decay_step;
                    end
                end
                ADSR_SUSTAIN: begin
                    if (sus_next >= {1'b0, sus_time}) begin
                        sus_cnt <= '0;
                        state   <= ADSR_RELEASE;
                    end else begin
                        sus_cnt <= sus_next[31:0];
                    end
                end
                ADSR_RELEASE: begin
                    if (env <= release_step) begin
                        env   <= '0;
                        state <= ADSR_IDLE;
                    end else begin
                        env <= env - release_step;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (req.reg_addr)
            `ADSR_REG_ATTACK:   read_data = {16'd0, attack_step};
            `ADSR_REG_DECAY:    read_data = {16'd0, decay_step};
            `ADSR_REG_SUSTAIN:  read_data = {16'd0, sustain_level};
            `ADSR_REG_SUS_TIME: read_data = sus_time;
            `ADSR_REG_RELEASE:  read_data = {16'd0, release_step};
            `ADSR_REG_STATUS:   read_data = {13'd0, state, env};
            default:            read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/mmio_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "mmio_defs.svh"

module mmio_controller (
    input  logic                mmio_cs,
    input  logic                mmio_write,
    input  logic                mmio_read,
    input  mmio_pkg::bus_addr_t mmio_addr,
    input  mmio_pkg::word_t     mmio_write_data,
    output mmio_pkg::word_t     mmio_read_data,
    output mmio_pkg::slot_req_t slot_req [`IO_NUM_SLOTS],
    input  mmio_pkg::word_t     slot_read_data [`IO_NUM_SLOTS]
);

    import mmio_pkg::*;

    slot_idx_t slot_idx;
    reg_addr_t reg_addr;

    // Upper address bits are ignored
    assign slot_idx = mmio_addr[10:5];
    assign reg_addr = mmio_addr[4:0];

    always_comb begin
        for (int i = 0; i < `IO_NUM_SLOTS; i++) begin
            slot_req[i].cs         = mmio_cs && (slot_idx == slot_idx_t'(i));
            slot_req[i].read       = slot_req[i].cs && mmio_read;
            slot_req[i].write      = slot_req[i].cs && mmio_write;
            slot_req[i].reg_addr   = reg_addr;
            slot_req[i].write_data = mmio_write_data;
        end
    end

    // Read path is purely combinational
    assign mmio_read_data = mmio_cs ? slot_read_data[slot_idx] : '0;

endmodule

`default_nettype wire

// File: rtl/mmio_ddfs.sv
`timescale 1ns/100ps
`default_nettype none

`include "mmio_defs.svh"

module mmio_ddfs (
    input  logic                clk,
    input  logic                arst_n,
    input  mmio_pkg::slot_req_t req,
    output mmio_pkg::word_t     read_data,
    input  mmio_pkg::env_t      env_ext,
    output mmio_pkg::pcm_t      pcm_out
);

    import mmio_pkg::*;

    phase_t fccw;
    phase_t phase;
    env_t   env_fixed;
    env_t   env_cur;
    logic   env_sel;
    pcm_t   saw;

    logic signed [32:0] product;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fccw      <= '0;
            env_sel   <= 1'b0;
            env_fixed <= '0;
        end else if (req.write) begin
            case (req.reg_addr)
                `DDFS_REG_FCCW: fccw      <= req.write_data;
                `DDFS_REG_CTRL: env_sel   <= req.write_data[0];
                `DDFS_REG_ENV:  env_fixed <= req.write_data[15:0];
                default: ;
            endcase
        end
    end

    // Phase accumulator, a write overrides it for one edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else if (req.write && (req.reg_addr == `DDFS_REG_PHASE)) begin
            phase <= req.write_data;
        end else begin
            phase <= phase + fccw;
        end
    end

    assign saw     = pcm_t'(phase[31:16]);
    assign env_cur = env_sel ? env_ext : env_fixed;

    // Envelope is unsigned Q1.15, so widen with a zero sign bit
    assign product = saw * $signed({1'b0, env_cur});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pcm_out <= '0;
        end else begin
            pcm_out <= product[30:15];
        end
    end

    always_comb begin
        case (req.reg_addr)
            `DDFS_REG_FCCW:  read_data = fccw;
            `DDFS_REG_CTRL:  read_data = {31'd0, env_sel};
            `DDFS_REG_ENV:   read_data = {16'd0, env_fixed};
            `DDFS_REG_PHASE: read_data = phase;
            default:         read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/mmio_defs.svh
`ifndef MMIO_DEFS_SVH
`define MMIO_DEFS_SVH

// Slot map
`define IO_S0_GPO               0
`define IO_S1_DDFS              1
`define IO_S2_ADSR              2
`define IO_NUM_SLOTS            64

// DDFS register offsets
`define DDFS_REG_FCCW           5'd0
`define DDFS_REG_CTRL           5'd1
`define DDFS_REG_ENV            5'd2
`define DDFS_REG_PHASE          5'd3

// ADSR register offsets
`define ADSR_REG_ATTACK         5'd0
`define ADSR_REG_DECAY          5'd1
`define ADSR_REG_SUSTAIN        5'd2
`define ADSR_REG_SUS_TIME       5'd3
`define ADSR_REG_RELEASE        5'd4
`define ADSR_REG_START          5'd5
`define ADSR_REG_STATUS         5'd6

// Full-scale envelope, unity gain in Q1.15
`define ENV_MAX                 16'h7fff

// clk cycles per half period of the I2S bit clock
`define I2S_SCLK_DIV            4

`endif

// File: rtl/mmio_gpo.sv
`timescale 1ns/100ps
`default_nettype none

module mmio_gpo (
    input  logic                clk,
    input  logic                arst_n,
    input  mmio_pkg::slot_req_t req,
    output mmio_pkg::word_t     read_data,
    output mmio_pkg::word_t     d_out
);

    import mmio_pkg::*;

    word_t gpo_reg;

    // Any offset inside the slot maps to the one register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpo_reg <= '0;
        end else if (req.write) begin
            gpo_reg <= req.write_data;
        end
    end

    assign read_data = gpo_reg;
    assign d_out     = gpo_reg;

endmodule

`default_nettype wire

// File: rtl/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    typedef logic [20:0] bus_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0] slot_idx_t;
    typedef logic [4:0] reg_addr_t;

    typedef logic [31:0] phase_t;
    typedef logic [15:0] env_t;
    typedef logic signed [15:0] pcm_t;

    // Everything a slot sees of the bus
    typedef struct packed {
        logic cs;
        logic read;
        logic write;
        reg_addr_t reg_addr;
        word_t write_data;
    } slot_req_t;

    typedef enum logic [2:0] {
        ADSR_IDLE    = 3'd0,
        ADSR_ATTACK  = 3'd1,
        ADSR_DECAY   = 3'd2,
        ADSR_SUSTAIN = 3'd3,
        ADSR_RELEASE = 3'd4
    } adsr_state_t;

endpackage

`default_nettype wire

// File: rtl/mmio_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mmio_defs.svh"

module mmio_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                mmio_cs,
    input  logic                mmio_write,
    input  logic                mmio_read,
    input  mmio_pkg::bus_addr_t mmio_addr,
    input  mmio_pkg::word_t     mmio_write_data,
    output mmio_pkg::word_t     mmio_read_data,
    output logic [3:0]          led,
    output logic                audio_tx_mclk,
    output logic                audio_tx_sclk,
    output logic                audio_tx_lrclk,
    output logic                audio_tx_sd
);

    import mmio_pkg::*;

    slot_req_t slot_req [`IO_NUM_SLOTS];
    word_t     slot_read_data [`IO_NUM_SLOTS];
    word_t     gpo;
    env_t      env;
    pcm_t      pcm;

    mmio_controller ctrl_i (
        .mmio_cs         (mmio_cs),
        .mmio_write      (mmio_write),
        .mmio_read       (mmio_read),
        .mmio_addr       (mmio_addr),
        .mmio_write_data (mmio_write_data),
        .mmio_read_data  (mmio_read_data),
        .slot_req        (slot_req),
        .slot_read_data  (slot_read_data)
    );

    mmio_gpo gpo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (slot_req[`IO_S0_GPO]),
        .read_data (slot_read_data[`IO_S0_GPO]),
        .d_out     (gpo)
    );

    assign led = gpo[3:0];

    mmio_ddfs ddfs_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (slot_req[`IO_S1_DDFS]),
        .read_data (slot_read_data[`IO_S1_DDFS]),
        .env_ext   (env),
        .pcm_out   (pcm)
    );

    mmio_adsr adsr_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (slot_req[`IO_S2_ADSR]),
        .read_data (slot_read_data[`IO_S2_ADSR]),
        .env       (env)
    );

    // Mono sample on both channels
    i2s_tx i2s_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .audio_l  (pcm),
        .audio_r  (pcm),
        .tx_mclk  (audio_tx_mclk),
        .tx_sclk  (audio_tx_sclk),
        .tx_lrclk (audio_tx_lrclk),
        .tx_sd    (audio_tx_sd)
    );

    // Empty slots read as all ones
    for (genvar i = `IO_S2_ADSR + 1; i < `IO_NUM_SLOTS; i++) begin : g_unused_slot
        assign slot_read_data[i] = 32'hffff_ffff;
    end

endmodule

`default_nettype wire

// File: tests/tb_mmio_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mmio_defs.svh"

module tb_mmio_top;

    import mmio_pkg::*;

    localparam int          CLK_PERIOD    = 8;
    localparam logic [31:0] SEED          = 32'h37cc_a864;
    localparam int          FRAME_TIMEOUT = 1024;
    localparam int          BIT_TIMEOUT   = 4 * `I2S_SCLK_DIV;
    localparam int          POLL_LIMIT    = 1000;

    logic       clk;
    logic       arst_n;
    logic       mmio_cs;
    logic       mmio_write;
    logic       mmio_read;
    bus_addr_t  mmio_addr;
    word_t      mmio_write_data;
    word_t      mmio_read_data;
    logic [3:0] led;
    logic       audio_tx_mclk;
    logic       audio_tx_sclk;
    logic       audio_tx_lrclk;
    logic       audio_tx_sd;

    mmio_top dut_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .mmio_cs         (mmio_cs),
        .mmio_write      (mmio_write),
        .mmio_read       (mmio_read),
        .mmio_addr       (mmio_addr),
        .mmio_write_data (mmio_write_data),
        .mmio_read_data  (mmio_read_data),
        .led             (led),
        .audio_tx_mclk   (audio_tx_mclk),
        .audio_tx_sclk   (audio_tx_sclk),
        .audio_tx_lrclk  (audio_tx_lrclk),
        .audio_tx_sd     (audio_tx_sd)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                    $time, name, actual, expected));
        end
    endtask

    function automatic bus_addr_t slot_addr(input int slot, input int offset,
                                            input logic [9:0] upper);
        return {upper, slot_idx_t'(slot), reg_addr_t'(offset)};
    endfunction

    // Sawtooth is the signed top half of the phase, scaled by a Q1.15 level
    function automatic pcm_t expected_sample(input phase_t ph, input env_t level);
        logic signed [47:0] saw;
        logic signed [47:0] prod;
        logic signed [47:0] scaled;
        saw    = {{32{ph[31]}}, ph[31:16]};
        prod   = saw * $signed({32'd0, level});
        scaled = prod >>> 15;
        return scaled[15:0];
    endfunction

    // Bus tasks start and end on a falling clk edge
    task automatic bus_write(input bus_addr_t addr, input word_t data);
        mmio_cs         = 1'b1;
        mmio_write      = 1'b1;
        mmio_addr       = addr;
        mmio_write_data = data;
        @(negedge clk);
        mmio_cs    = 1'b0;
        mmio_write = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output word_t data);
        mmio_cs   = 1'b1;
        mmio_read = 1'b1;
        mmio_addr = addr;
        #(CLK_PERIOD / 4);
        data = mmio_read_data;
        @(negedge clk);
        mmio_cs   = 1'b0;
        mmio_read = 1'b0;
    endtask

    task automatic i2s_capture(output pcm_t left, output pcm_t right);
        logic [32:0] bits;
        logic        prev_lr;
        logic        prev_sclk;
        logic        edge_seen;
        int          waited;
        bits    = '0;
        prev_lr = audio_tx_lrclk;
        waited  = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > FRAME_TIMEOUT) begin
                stop_on_error("Timeout waiting for the start of an I2S frame");
            end
            edge_seen = prev_lr && !audio_tx_lrclk;
            prev_lr   = audio_tx_lrclk;
        end while (!edge_seen);
        prev_sclk = audio_tx_sclk;
        for (int b = 0; b < 33; b++) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                if (waited > BIT_TIMEOUT) begin
                    stop_on_error("Timeout waiting for a rising edge of the I2S bit clock");
                end
                edge_seen = !prev_sclk && audio_tx_sclk;
                prev_sclk = audio_tx_sclk;
            end while (!edge_seen);
            bits = {bits[31:0], audio_tx_sd};
        end
        // bits[32] is the last bit of the previous frame
        left  = bits[31:16];
        right = bits[15:0];
    endtask

    task automatic ddfs_setup(input word_t ctrl, input phase_t ph);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_FCCW, 10'd0), 32'd0);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_PHASE, 10'd0), ph);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_CTRL, 10'd0), ctrl);
    endtask

    task automatic adsr_setup(input env_t attack, input env_t decay, input env_t sustain,
                              input word_t sus_time, input env_t release_step);
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_ATTACK, 10'd0), {16'd0, attack});
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_DECAY, 10'd0), {16'd0, decay});
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_SUSTAIN, 10'd0), {16'd0, sustain});
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_SUS_TIME, 10'd0), sus_time);
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_RELEASE, 10'd0), {16'd0, release_step});
        bus_write(slot_addr(`IO_S2_ADSR, `ADSR_REG_START, 10'd0), 32'd0);
    endtask

    // mclk flips every clk, sclk holds for the divider count
    task automatic clock_outputs();
        logic prev_mclk;
        logic prev_sclk;
        int   run;
        prev_mclk = audio_tx_mclk;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_value("audio_tx_mclk", {31'd0, audio_tx_mclk}, {31'd0, ~prev_mclk});
            prev_mclk = audio_tx_mclk;
        end
        prev_sclk = audio_tx_sclk;
        run       = 0;
        do begin
            @(negedge clk);
            run++;
            if (run > BIT_TIMEOUT) begin
                stop_on_error("Timeout waiting for the I2S bit clock to toggle");
            end
        end while (audio_tx_sclk == prev_sclk);
        prev_sclk = audio_tx_sclk;
        run       = 0;
        do begin
            @(negedge clk);
            run++;
            if (run > BIT_TIMEOUT) begin
                stop_on_error("Timeout waiting for the I2S bit clock to toggle");
            end
        end while (audio_tx_sclk == prev_sclk);
        check_value("audio_tx_sclk half period", run, `I2S_SCLK_DIV);
    endtask

    task automatic gpo_readback();
        word_t data;
        word_t rd;
        for (int i = 0; i < 8; i++) begin
            data = $urandom();
            bus_write(slot_addr(`IO_S0_GPO, $urandom_range(31, 0), 10'd0), data);
            bus_read(slot_addr(`IO_S0_GPO, $urandom_range(31, 0), 10'd0), rd);
            check_value("gpo read_data", rd, data);
            check_value("led", {28'd0, led}, {28'd0, data[3:0]});
        end
    endtask

    task automatic slot_decode();
        int    slots [3] = '{3, 17, 63};
        int    offs  [4] = '{`DDFS_REG_FCCW, `DDFS_REG_CTRL, `DDFS_REG_ENV, `DDFS_REG_PHASE};
        word_t masks [4] = '{32'hffff_ffff, 32'h1, 32'hffff, 32'hffff_ffff};
        word_t rd;
        word_t val;
        foreach (slots[i]) begin
            bus_read(slot_addr(slots[i], $urandom_range(31, 0), 10'd0), rd);
            check_value($sformatf("slot %0d read_data", slots[i]), rd, 32'hffff_ffff);
        end
        // Upper address bits must not affect the decode
        foreach (offs[i]) begin
            val = $urandom() & masks[i];
            bus_write(slot_addr(`IO_S1_DDFS, offs[i], 10'($urandom())), val);
            bus_read(slot_addr(`IO_S1_DDFS, offs[i], 10'($urandom())), rd);
            check_value($sformatf("ddfs reg %0d", offs[i]), rd, val);
        end
    endtask

    task automatic phase_step();
        phase_t fccw;
        phase_t start;
        word_t  first;
        word_t  second;
        int     n;
        fccw  = $urandom();
        start = $urandom();
        n     = $urandom_range(40, 3);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_FCCW, 10'd0), fccw);
        bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_PHASE, 10'd0), start);
        bus_read(slot_addr(`IO_S1_DDFS, `DDFS_REG_PHASE, 10'd0), first);
        repeat (n - 1) @(negedge clk);
        bus_read(slot_addr(`IO_S1_DDFS, `DDFS_REG_PHASE, 10'd0), second);
        check_value("ddfs phase after load", first, start);
        check_value("ddfs phase step", second - first, phase_t'(n) * fccw);
    endtask

    task automatic ddfs_frame();
        env_t   levels [3];
        phase_t ph;
        pcm_t   left;
        pcm_t   right;
        levels[0] = '0;
        levels[1] = `ENV_MAX;
        levels[2] = env_t'($urandom_range(`ENV_MAX, 1));
        ph = $urandom();
        ddfs_setup(32'd0, ph);
        foreach (levels[i]) begin
            bus_write(slot_addr(`IO_S1_DDFS, `DDFS_REG_ENV, 10'd0), {16'd0, levels[i]});
            // Give pcm_out time to settle before the next frame latch
            repeat (4) @(negedge clk);
            i2s_capture(left, right);
            check_value("i2s left", {16'd0, left}, {16'd0, expected_sample(ph, levels[i])});
            check_value("i2s right", {16'd0, right}, {16'd0, left});
        end
    endtask

    task automatic adsr_cycle();
        env_t        sustain;
        word_t       sus_time;
        word_t       status;
        adsr_state_t state;
        adsr_state_t prev;
        adsr_state_t succ;
        int          sus_polls;
        int          polls;
        sustain  = env_t'($urandom_range(16'h5fff, 16'h1000));
        sus_time = $urandom_range(60, 20);
        adsr_setup(env_t'($urandom_range(16'h0fff, 16'h0200)),
                   env_t'($urandom_range(16'h03ff, 16'h0100)), sustain,
                   sus_time, env_t'($urandom_range(16'h03ff, 16'h0100)));
        prev      = ADSR_ATTACK;
        sus_polls = 0;
        polls     = 0;
        // One poll per clk, so every state shows up
        do begin
            bus_read(slot_addr(`IO_S2_ADSR, `ADSR_REG_STATUS, 10'd0), status);
            polls++;
            if (polls > POLL_LIMIT) begin
                stop_on_error("Timeout waiting for the ADSR to return to idle");
            end
            state = adsr_state_t'(status[18:16]);
            succ  = (prev == ADSR_RELEASE) ? ADSR_IDLE : adsr_state_t'(prev + 3'd1);
            if (state != prev) begin
                check_value("adsr state", 32'(state), 32'(succ));
            end
            if (state == ADSR_SUSTAIN) begin
                sus_polls++;
                check_value("adsr env in sustain", {16'd0, status[15:0]}, {16'd0, sustain});
            end
            prev = state;
        end while (state != ADSR_IDLE);
        check_value("adsr sustain cycles", sus_polls, sus_time);
        check_value("adsr env at idle", {16'd0, status[15:0]}, 32'd0);
    endtask

    task automatic adsr_into_ddfs();
        env_t   sustain;
        phase_t ph;
        word_t  status;
        pcm_t   left;
        pcm_t   right;
        int     polls;
        sustain = env_t'($urandom_range(16'h6fff, 16'h1000));
        ph      = $urandom();
        ddfs_setup(32'd1, ph);
        adsr_setup(16'h0800, 16'h0400, sustain, 32'd100_000, 16'h0100);
        polls = 0;
        do begin
            bus_read(slot_addr(`IO_S2_ADSR, `ADSR_REG_STATUS, 10'd0), status);
            polls++;
            if (polls > POLL_LIMIT) begin
                stop_on_error("Timeout waiting for the ADSR to reach sustain");
            end
        end while (status[18:16] != ADSR_SUSTAIN);
        check_value("adsr env in sustain", {16'd0, status[15:0]}, {16'd0, sustain});
        repeat (4) @(negedge clk);
        i2s_capture(left, right);
        check_value("i2s left", {16'd0, left}, {16'd0, expected_sample(ph, sustain)});
        check_value("i2s right", {16'd0, right}, {16'd0, left});
    endtask

    initial begin
        word_t rd;
        void'($urandom(SEED));
        arst_n          = 1'b0;
        mmio_cs         = 1'b0;
        mmio_write      = 1'b0;
        mmio_read       = 1'b0;
        mmio_addr       = '0;
        mmio_write_data = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        check_value("led after reset", {28'd0, led}, 32'd0);
        check_value("i2s outputs after reset",
                    {28'd0, audio_tx_mclk, audio_tx_sclk, audio_tx_lrclk, audio_tx_sd}, 32'd0);
        bus_read(slot_addr(`IO_S2_ADSR, `ADSR_REG_STATUS, 10'd0), rd);
        check_value("adsr status after reset", rd, 32'd0);
        clock_outputs();
        gpo_readback();
        slot_decode();
        phase_step();
        ddfs_frame();
        adsr_cycle();
        adsr_into_ddfs();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
